//--- source/scan_pkg.sv
// scan package: constants, read-port address layout and the types passed between stages
package scan_pkg;

   // ---------------------------------------------------------------------------
   // read port and address layout
   // ---------------------------------------------------------------------------
   localparam int scan_word_w = 32;     // rd_data width
   localparam int row_w       = 13;
   localparam int col_w       = 10;
   localparam int bank_w      = 2;
   localparam int xfr_len_w   = 10;     // rd_xfr_len width

   // ---------------------------------------------------------------------------
   // scan range and expected pattern
   // ---------------------------------------------------------------------------
   localparam logic [row_w-1:0] scan_row_last = 7;   // row 7 wraps to 0
   localparam int burst_words = 16;                   // words per row

   // length value driven on the read port
   localparam logic [xfr_len_w-1:0] burst_len = xfr_len_w'(burst_words);

   // bytes 10, 86, cb, fd from low to high
   localparam logic [scan_word_w-1:0] preload_word = 32'hFDCB_8610;

   localparam int screen_cnt_w = 16;

   // fault log
   localparam int fault_depth   = 16;
   localparam int fault_count_w = 5;    // holds 0..fault_depth
   localparam int fault_ptr_w   = 4;
   localparam int fault_row_w   = 10;   // low bits of the row kept in the log

   // ---------------------------------------------------------------------------
   // types
   // ---------------------------------------------------------------------------
   typedef struct packed {
      logic [row_w-1:0]  row;
      logic [col_w-1:0]  col;
      logic [bank_w-1:0] bank;
   } mem_addr_t;                        // 25 bits, row in the msbs

   typedef enum logic [1:0] {
      idle       = 2'b00,
      wait_grant = 2'b01,
      pre_xfr    = 2'b10,   // granted, first word not yet seen
      data_xfr   = 2'b11
   } req_state_e;

   // sequencer to requester
   typedef struct packed {
      logic             go;
      logic [row_w-1:0] row;
   } row_cmd_t;

   // requester to checker
   typedef struct packed {
      logic             req_pulse;   // first cycle of a request
      logic             in_xfr;      // data phase of the burst
      logic [row_w-1:0] row;
   } burst_info_t;

endpackage

//--- source/row_sequencer.sv
// row sequencer: starts the scan on init_done, steps rows and screens, pulses go
`timescale 1ns/1ps

module row_sequencer (
   input  logic                            mem_clk90,
   input  logic                            mem_rst,
   input  logic                            init_done,
   input  logic                            xfr_done,
   output scan_pkg::row_cmd_t              cmd,
   output logic [scan_pkg::row_w-1:0]      scan_row,
   output logic [scan_pkg::screen_cnt_w-1:0] screen_count
);

   import scan_pkg::*;

   logic init_done_d;   // previous sample of init_done
   logic start_edge;
   logic go_q;

   assign start_edge = init_done & ~init_done_d;

   // ---------------------------------------------------------------------------
   // go pulse
   // ---------------------------------------------------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         init_done_d <= 1'b0;
         go_q        <= 1'b0;
      end else begin
         init_done_d <= init_done;
         go_q        <= start_edge | xfr_done;   // first row, then one per finished burst
      end
   end

   // ---------------------------------------------------------------------------
   // row and screen counters
   // ---------------------------------------------------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         scan_row     <= '0;
         screen_count <= '0;
      end else if (xfr_done) begin
         if (scan_row == scan_row_last) begin
            scan_row     <= '0;
            screen_count <= screen_count + 1'b1;   // full screen read back
         end else begin
            scan_row <= scan_row + 1'b1;
         end
      end
   end

   // row has already stepped when go goes out
   assign cmd.go  = go_q;
   assign cmd.row = scan_row;

   // a go pulse always waits for a whole burst before the next one
   go_single_pulse: assert property (
      @(posedge mem_clk90) disable iff (mem_rst)
      go_q |=> !go_q
   );

endmodule

//--- source/read_requester.sv
// read requester: request/grant FSM on the read port, tracks each burst to its end
`timescale 1ns/1ps

module read_requester (
   input  logic                           mem_clk90,
   input  logic                           mem_rst,
   input  scan_pkg::row_cmd_t             cmd,
   output logic                           rd_mem_req,
   output scan_pkg::mem_addr_t            rd_mem_addr,
   output logic [scan_pkg::xfr_len_w-1:0] rd_xfr_len,
   input  logic                           rd_mem_grant,
   input  logic                           rd_data_valid,
   output scan_pkg::burst_info_t          burst,
   output logic                           xfr_done
);

   import scan_pkg::*;

   req_state_e state_q, state_nxt;
   logic       req_nxt;
   logic       done_nxt;
   logic       req_pulse_q;
   logic       start;

   assign start = (state_q == idle) & cmd.go;

   // ---------------------------------------------------------------------------
   // state and control registers
   // ---------------------------------------------------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         state_q     <= idle;
         rd_mem_req  <= 1'b0;
         xfr_done    <= 1'b0;
         req_pulse_q <= 1'b0;
      end else begin
         state_q     <= state_nxt;
         rd_mem_req  <= req_nxt;
         xfr_done    <= done_nxt;
         req_pulse_q <= start;   // lines up with the first cycle of rd_mem_req
      end
   end

   // address and length, held for the whole burst
   always_ff @(posedge mem_clk90) begin
      if (start) begin
         rd_mem_addr.row  <= cmd.row;
         rd_mem_addr.col  <= '0;
         rd_mem_addr.bank <= '0;
         rd_xfr_len       <= burst_len;
      end
   end

   // ---------------------------------------------------------------------------
   // next state
   // ---------------------------------------------------------------------------
   always_comb begin
      state_nxt = state_q;
      req_nxt   = 1'b0;
      done_nxt  = 1'b0;
      case (state_q)
         idle: begin
            if (cmd.go) begin
               state_nxt = wait_grant;
               req_nxt   = 1'b1;
            end
         end
         wait_grant: begin
            req_nxt = 1'b1;        // hold until the memory answers
            if (rd_mem_grant) begin
               state_nxt = pre_xfr;
               req_nxt   = 1'b0;
            end
         end
         pre_xfr: begin
            if (rd_data_valid) state_nxt = data_xfr;
         end
         data_xfr: begin
            // end of the valid run ends the transfer
            if (!rd_data_valid) begin
               state_nxt = idle;
               done_nxt  = 1'b1;
            end
         end
         default: state_nxt = idle;
      endcase
   end

   assign burst.req_pulse = req_pulse_q;
   assign burst.in_xfr    = (state_q == pre_xfr) | (state_q == data_xfr);
   assign burst.row       = rd_mem_addr.row;

   // request is a level held across any grant delay
   req_held_to_grant: assert property (
      @(posedge mem_clk90) disable iff (mem_rst)
      rd_mem_req && !rd_mem_grant |=> rd_mem_req
   );

endmodule

//--- source/burst_checker.sv
// burst checker: compares read data with the preload pattern and logs one fault per row
`timescale 1ns/1ps

module burst_checker (
   input  logic                             mem_clk90,
   input  logic                             mem_rst,
   input  scan_pkg::burst_info_t            burst,
   input  logic [scan_pkg::scan_word_w-1:0] rd_data,
   input  logic                             rd_data_valid,
   output logic                             fault_push,
   output logic [scan_pkg::fault_row_w-1:0] fault_row
);

   import scan_pkg::*;

   logic fault_latch;
   logic fault_latch_d;
   logic word_bad;

   assign word_bad = rd_data_valid & burst.in_xfr & (rd_data != preload_word);

   // ---------------------------------------------------------------------------
   // fault latch, one per row
   // ---------------------------------------------------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         fault_latch <= 1'b0;
      end else if (burst.req_pulse) begin
         fault_latch <= 1'b0;       // new row starting
      end else if (word_bad) begin
         fault_latch <= 1'b1;       // further bad words in the row change nothing
      end
   end

   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         fault_latch_d <= 1'b0;
      end else begin
         fault_latch_d <= fault_latch;
      end
   end

   // rising edge of the latch logs the row once
   assign fault_push = fault_latch & ~fault_latch_d;

   // row stays latched in the requester well past the push
   assign fault_row = burst.row[fault_row_w-1:0];

   // push lands while the faulty row is still being read
   fault_push_in_burst: assert property (
      @(posedge mem_clk90) disable iff (mem_rst)
      fault_push |-> burst.in_xfr
   );

endmodule

//--- source/fault_log_fifo.sv
// fault log: circular buffer of faulty row numbers with pop, count and overflow flag
`timescale 1ns/1ps

module fault_log_fifo (
   input  logic                               mem_clk90,
   input  logic                               mem_rst,
   input  logic                               push,
   input  logic [scan_pkg::fault_row_w-1:0]   push_row,
   input  logic                               pop,
   output logic                               fault_valid,
   output logic [scan_pkg::fault_row_w-1:0]   fault_row,
   output logic [scan_pkg::fault_count_w-1:0] fault_count,
   output logic                               fault_overflow
);

   import scan_pkg::*;

   logic [fault_row_w-1:0] mem [fault_depth];
   logic [fault_ptr_w-1:0] wr_ptr;
   logic [fault_ptr_w-1:0] rd_ptr;
   logic                   full;
   logic                   do_push;
   logic                   do_pop;

   assign full    = (fault_count == fault_count_w'(fault_depth));
   assign do_push = push & ~full;
   assign do_pop  = pop & fault_valid;    // pop on empty ignored

   // ---------------------------------------------------------------------------
   // storage
   // ---------------------------------------------------------------------------
   always_ff @(posedge mem_clk90) begin
      if (do_push) mem[wr_ptr] <= push_row;
   end

   // ---------------------------------------------------------------------------
   // pointers, count, overflow
   // ---------------------------------------------------------------------------
   always_ff @(posedge mem_clk90) begin
      if (mem_rst) begin
         wr_ptr         <= '0;
         rd_ptr         <= '0;
         fault_count    <= '0;
         fault_overflow <= 1'b0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;

         case ({do_push, do_pop})
            2'b10:   fault_count <= fault_count + 1'b1;
            2'b01:   fault_count <= fault_count - 1'b1;
            default: fault_count <= fault_count;
         endcase

         // sticky, a lost row is never forgotten
         if (push & full) fault_overflow <= 1'b1;
      end
   end

   assign fault_valid = (fault_count != '0);
   assign fault_row   = mem[rd_ptr];   // head entry

   count_in_range: assert property (
      @(posedge mem_clk90) disable iff (mem_rst)
      fault_count <= fault_count_w'(fault_depth)
   );

endmodule

//--- source/mem_scan_top.sv
// memory scan top: row sequencer, read requester, burst checker and fault log in a chain
`timescale 1ns/1ps

module mem_scan_top (
   input  logic                                mem_clk90,
   input  logic                                mem_rst,
   input  logic                                init_done,
   // read port
   output logic                                rd_mem_req,
   output scan_pkg::mem_addr_t                 rd_mem_addr,
   output logic [scan_pkg::xfr_len_w-1:0]      rd_xfr_len,
   input  logic                                rd_mem_grant,
   input  logic [scan_pkg::scan_word_w-1:0]    rd_data,
   input  logic                                rd_data_valid,
   // fault log
   input  logic                                fault_pop,
   output logic                                fault_valid,
   output logic [scan_pkg::fault_row_w-1:0]    fault_row,
   output logic [scan_pkg::fault_count_w-1:0]  fault_count,
   output logic                                fault_overflow,
   // progress
   output logic [scan_pkg::row_w-1:0]          scan_row,
   output logic [scan_pkg::screen_cnt_w-1:0]   screen_count
);

   import scan_pkg::*;

   row_cmd_t               cmd;
   burst_info_t            burst;
   logic                   xfr_done;
   logic                   fault_push;
   logic [fault_row_w-1:0] push_row;

   row_sequencer row_sequencer_inst (
      .mem_clk90    ( mem_clk90    ),
      .mem_rst      ( mem_rst      ),
      .init_done    ( init_done    ),
      .xfr_done     ( xfr_done     ),
      .cmd          ( cmd          ),
      .scan_row     ( scan_row     ),
      .screen_count ( screen_count )
   );

   read_requester read_requester_inst (
      .mem_clk90     ( mem_clk90     ),
      .mem_rst       ( mem_rst       ),
      .cmd           ( cmd           ),
      .rd_mem_req    ( rd_mem_req    ),
      .rd_mem_addr   ( rd_mem_addr   ),
      .rd_xfr_len    ( rd_xfr_len    ),
      .rd_mem_grant  ( rd_mem_grant  ),
      .rd_data_valid ( rd_data_valid ),
      .burst         ( burst         ),
      .xfr_done      ( xfr_done      )
   );

   burst_checker burst_checker_inst (
      .mem_clk90     ( mem_clk90     ),
      .mem_rst       ( mem_rst       ),
      .burst         ( burst         ),
      .rd_data       ( rd_data       ),
      .rd_data_valid ( rd_data_valid ),
      .fault_push    ( fault_push    ),
      .fault_row     ( push_row      )
   );

   fault_log_fifo fault_log_fifo_inst (
      .mem_clk90      ( mem_clk90      ),
      .mem_rst        ( mem_rst        ),
      .push           ( fault_push     ),
      .push_row       ( push_row       ),
      .pop            ( fault_pop      ),
      .fault_valid    ( fault_valid    ),
      .fault_row      ( fault_row      ),
      .fault_count    ( fault_count    ),
      .fault_overflow ( fault_overflow )
   );

endmodule

//--- verification/tb_clock_gen.sv
// testbench clock and reset: 100 ns mem_clk90, synchronous reset held for 5 cycles
`timescale 1ns/1ps

module tb_clock_gen (
   output logic mem_clk90,
   output logic mem_rst
);

   localparam time half_period = 50;   // ns
   localparam int  reset_cycles = 5;

   initial begin
      mem_clk90 = 1'b0;
      forever #half_period mem_clk90 = ~mem_clk90;
   end

   initial begin
      mem_rst = 1'b1;
      repeat (reset_cycles) @(posedge mem_clk90);
      mem_rst <= 1'b0;
   end

endmodule

//--- verification/mem_scan_tb.sv
// memory scan testbench: memory model fed from the test file, address, counter and fault log checks
`timescale 1ns/1ps

module mem_scan_tb;

   import scan_pkg::*;

   localparam logic [31:0] pattern_word = 32'hFDCB_8610;   // bytes 10 86 cb fd
   localparam int words_per_row   = 16;
   localparam int rows_per_screen = 8;
   localparam int log_depth       = 16;
   localparam int pre_init_cycles = 10;
   localparam int hold_cycles     = 20;

   logic        mem_clk90;
   logic        mem_rst;
   logic        init_done;
   logic        rd_mem_grant;
   logic [31:0] rd_data;
   logic        rd_data_valid;
   logic        fault_pop;
   logic        rd_mem_req;
   mem_addr_t   rd_mem_addr;
   logic [9:0]  rd_xfr_len;
   logic        fault_valid;
   logic [9:0]  fault_row;
   logic [4:0]  fault_count;
   logic        fault_overflow;
   logic [12:0] scan_row;
   logic [15:0] screen_count;

   int          idx_list[$];     // corrupted word per burst, 99 for none
   logic [31:0] mask_list[$];
   int          delay_list[$];   // grant delay in cycles
   int          exp_rows[$];     // rows expected in the fault log, oldest first

   int          cycle_count  = 0;
   int          cycle_limit  = 200;
   int          errors       = 0;
   int          test_errors  = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   logic [31:0] lcg_state    = 32'h5f95;

   tb_clock_gen tb_clock_gen_inst (
      .mem_clk90 ( mem_clk90 ),
      .mem_rst   ( mem_rst   )
   );

   mem_scan_top mem_scan_top_inst (
      .mem_clk90      ( mem_clk90      ),
      .mem_rst        ( mem_rst        ),
      .init_done      ( init_done      ),
      .rd_mem_req     ( rd_mem_req     ),
      .rd_mem_addr    ( rd_mem_addr    ),
      .rd_xfr_len     ( rd_xfr_len     ),
      .rd_mem_grant   ( rd_mem_grant   ),
      .rd_data        ( rd_data        ),
      .rd_data_valid  ( rd_data_valid  ),
      .fault_pop      ( fault_pop      ),
      .fault_valid    ( fault_valid    ),
      .fault_row      ( fault_row      ),
      .fault_count    ( fault_count    ),
      .fault_overflow ( fault_overflow ),
      .scan_row       ( scan_row       ),
      .screen_count   ( screen_count   )
   );

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
      errors++;
      test_errors++;
   endtask

   task automatic report_failure(input string text);
      $display("Error: %s", text);
      errors++;
      test_errors++;
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (test_errors != 0) begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, test_errors);
      end else begin
         $display("test %s: ok", name);
      end
      test_errors = 0;
   endtask

   task automatic load_tests();
      int          fd;
      int          code;
      string       line;
      int          idx;
      logic [31:0] mask;
      int          delay;
      fd = $fopen("verification/mem_scan_tests.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open verification/mem_scan_tests.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line.getc(0) != "#") begin
               if ($sscanf(line, "%d %h %d", idx, mask, delay) == 3) begin
                  idx_list.push_back(idx);
                  mask_list.push_back(mask);
                  delay_list.push_back(delay);
                  cycle_limit += delay + 40;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // sampled at the edge where the request is first seen
   task automatic check_address(input int k);
      string name;
      name = $sformatf("burst_%0d", k);
      if (rd_mem_addr.row != 13'(k % rows_per_screen))
         report_mismatch({name, " row"}, 32'(k % rows_per_screen), 32'(rd_mem_addr.row));
      if (rd_mem_addr.col != '0)
         report_mismatch({name, " column"}, 32'd0, 32'(rd_mem_addr.col));
      if (rd_mem_addr.bank != '0)
         report_mismatch({name, " bank"}, 32'd0, 32'(rd_mem_addr.bank));
      if (rd_xfr_len != 10'(words_per_row))
         report_mismatch({name, " length"}, 32'(words_per_row), 32'(rd_xfr_len));
   endtask

   // grant after the delay, random gap, then one contiguous run of words
   task automatic serve_burst(input int k);
      logic [31:0] rnd;
      logic [31:0] word;
      int          gap;
      repeat (delay_list[k]) begin
         @(posedge mem_clk90);
         if (!rd_mem_req) report_failure($sformatf("burst_%0d request dropped before grant", k));
      end
      @(posedge mem_clk90);
      rd_mem_grant <= 1'b1;
      rnd = next_rand();
      gap = int'(rnd[17:16]);   // 0..3 idle cycles
      for (int c = 0; c < gap + words_per_row; c++) begin
         @(posedge mem_clk90);
         rd_mem_grant <= 1'b0;
         if (c < gap) begin
            rd_data_valid <= 1'b0;
         end else begin
            word = pattern_word;
            if (c - gap == idx_list[k]) word = word ^ mask_list[k];
            rd_data_valid <= 1'b1;
            rd_data       <= word;
         end
      end
      @(posedge mem_clk90);
      rd_data_valid <= 1'b0;
      rd_data       <= '0;
      if (idx_list[k] < words_per_row && mask_list[k] != 0)
         exp_rows.push_back(k % rows_per_screen);
   endtask

   // ------------------------------------------------------------------------
   // run limit
   // ------------------------------------------------------------------------
   always @(posedge mem_clk90) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Error: run stopped after %0d cycles without finishing", cycle_count);
         $display("Something failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------------
   // stimulus and checks
   // ------------------------------------------------------------------------
   initial begin
      int          n_bursts;
      int          n_kept;
      logic [12:0] held_row;
      init_done     = 1'b0;
      rd_mem_grant  = 1'b0;
      rd_data       = '0;
      rd_data_valid = 1'b0;
      fault_pop     = 1'b0;
      load_tests();
      n_bursts = idx_list.size();

      @(posedge mem_clk90);
      while (mem_rst) @(posedge mem_clk90);
      repeat (pre_init_cycles) begin
         @(posedge mem_clk90);
         if (rd_mem_req) report_failure("request raised while init_done is low");
      end
      close_test("idle_before_init");
      init_done <= 1'b1;

      // the request after the last line is left without a grant
      for (int k = 0; k <= n_bursts; k++) begin
         @(posedge mem_clk90);
         while (!rd_mem_req) @(posedge mem_clk90);
         check_address(k);
         if (k < n_bursts) begin
            serve_burst(k);
            close_test($sformatf("burst_%0d", k));
         end
      end

      held_row = scan_row;
      repeat (hold_cycles) begin
         @(posedge mem_clk90);
         if (!rd_mem_req) report_failure("request dropped while the grant is withheld");
         if (scan_row != held_row) report_mismatch("grant_withheld scan_row", 32'(held_row),
                                                   32'(scan_row));
      end
      close_test("grant_withheld");

      if (scan_row != 13'(n_bursts % rows_per_screen))
         report_mismatch("counters scan_row", 32'(n_bursts % rows_per_screen), 32'(scan_row));
      if (screen_count != 16'(n_bursts / rows_per_screen))
         report_mismatch("counters screen_count", 32'(n_bursts / rows_per_screen),
                         32'(screen_count));
      close_test("counters");

      // fault log, nothing popped so far
      n_kept = (exp_rows.size() > log_depth) ? log_depth : exp_rows.size();
      @(posedge mem_clk90);
      if (fault_count != 5'(n_kept))
         report_mismatch("fault_log count", 32'(n_kept), 32'(fault_count));
      if (fault_overflow != (exp_rows.size() > log_depth))
         report_mismatch("fault_log overflow", 32'(exp_rows.size() > log_depth),
                         32'(fault_overflow));
      for (int i = 0; i < n_kept; i++) begin
         if (!fault_valid) begin
            report_failure($sformatf("fault log empty before entry %0d was read", i));
         end else if (fault_row != 10'(exp_rows[i])) begin
            report_mismatch($sformatf("fault_log entry %0d", i), 32'(exp_rows[i]),
                            32'(fault_row));
         end
         fault_pop <= 1'b1;
         @(posedge mem_clk90);
         fault_pop <= 1'b0;
         @(posedge mem_clk90);
      end
      if (fault_valid) report_failure("fault log still holds entries after all pops");
      close_test("fault_log");

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

//--- verification/mem_scan_tests.txt
# corrupt_word (decimal, 99 = none)  xor_mask (hex)  grant_delay (cycles)
# one line per burst, burst n reads row n mod 8
0 00000001 0
99 00000000 2
15 80000000 1
7 0000ff00 3
3 00000000 0
1 ffffffff 5
8 00010000 0
12 00000004 4
4 12345678 1
99 00000000 0
9 00000020 6
2 40000000 2
14 00000100 0
5 0f0f0f0f 3
6 00000000 1
10 00800000 12
11 00000002 0
13 a5a5a5a5 2
0 00000008 1
15 00000001 7
6 01000000 0
3 00040000 2

//--- filelist.f
source/scan_pkg.sv
source/row_sequencer.sv
source/read_requester.sv
source/burst_checker.sv
source/fault_log_fifo.sv
source/mem_scan_top.sv
verification/tb_clock_gen.sv
verification/mem_scan_tb.sv

//--- Makefile
# Verilator build and run of the memory scan testbench

VERILATOR ?= verilator
TOP       ?= mem_scan_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
